// File: ice_bus_pkg.sv
`default_nettype none

package ice_bus_pkg;

	typedef logic [7:0] byte_t;

	// One bit per GPIO pad
	typedef logic [23:0] gpio_word_t;

	// Reply FIFO in front of the UART transmitter
	localparam int TX_FIFO_DEPTH = 16;
	// Devices hold off below this much free space
	localparam int TX_FIFO_SLACK = 4;

endpackage

`default_nettype wire

// File: ice_msg_pkg.sv
`default_nettype none

package ice_msg_pkg;

	// Device addresses on the message bus
	localparam int ADDR_BASICS = 0;
	localparam int ADDR_GPIO = 1;

	// Commands understood by the basics device
	localparam logic [7:0] CMD_VERSION = 8'h56;
	localparam logic [7:0] CMD_SET_DIR = 8'h64;
	localparam logic [7:0] CMD_SET_LEVEL = 8'h6c;
	localparam logic [7:0] CMD_READ_GPIO = 8'h67;

	// ASCII NAK
	localparam logic [7:0] NAK_CODE = 8'h15;

	// Major then minor
	localparam logic [15:0] VERSION_ID = 16'h0102;

endpackage

`default_nettype wire

// File: ice_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ice_bus_if #(
	parameter int NUM_DEV = 2
);

	import ice_bus_pkg::*;

	// Host frame broadcast
	byte_t ma_data;
	byte_t ma_addr;
	logic ma_data_valid;
	logic ma_frame_valid;

	// Reply lanes, one per device
	byte_t sl_data [NUM_DEV];
	logic [NUM_DEV-1:0] sl_data_latch;
	logic [NUM_DEV-1:0] sl_arb_request;
	logic [NUM_DEV-1:0] sl_arb_grant;
	// Reply FIFO close to full
	logic sl_overflow;

	modport master (
		output ma_data, ma_addr, ma_data_valid, ma_frame_valid,
		output sl_overflow, sl_arb_grant,
		input sl_data, sl_data_latch, sl_arb_request
	);

	modport device (
		input ma_data, ma_addr, ma_data_valid, ma_frame_valid,
		input sl_overflow, sl_arb_grant,
		output sl_data, sl_data_latch, sl_arb_request
	);

endinterface

`default_nettype wire

// File: uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart #(
	parameter int DIVIDE_FACTOR = 174
) (
	input wire clk,
	input wire rst_n,
	input wire rx_in,
	output logic tx_out,
	input wire tx_latch,
	input wire ice_bus_pkg::byte_t tx_data,
	output logic tx_empty,
	output ice_bus_pkg::byte_t rx_data,
	output logic rx_latch
);

	import ice_bus_pkg::*;

	localparam int CW = $clog2(DIVIDE_FACTOR);
	// Start bit sampled mid-bit, then one full bit per step
	localparam logic [CW-1:0] HALF_BIT = CW'(DIVIDE_FACTOR / 2);
	localparam logic [CW-1:0] FULL_BIT = CW'(DIVIDE_FACTOR - 1);

	logic [1:0] rx_sync;
	logic rx_busy;
	logic [CW-1:0] rx_cnt;
	logic [3:0] rx_bit;
	byte_t rx_shift;

	logic [9:0] tx_sr;
	logic [CW-1:0] tx_cnt;
	logic [3:0] tx_bit;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
			rx_busy <= 1'b0;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_latch <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx_in};
			rx_latch <= 1'b0;
			if (!rx_busy) begin
				// Falling edge of a start bit
				if (!rx_sync[1]) begin
					rx_busy <= 1'b1;
					rx_cnt <= HALF_BIT;
					rx_bit <= '0;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - CW'(1);
			end else begin
				rx_cnt <= FULL_BIT;
				rx_bit <= rx_bit + 4'd1;
				if (rx_bit == 4'd0 && rx_sync[1]) begin
					// Line high again so the start was a glitch
					rx_busy <= 1'b0;
				end else if (rx_bit == 4'd9) begin
					rx_busy <= 1'b0;
					// Byte kept only with a good stop bit
					rx_latch <= rx_sync[1];
				end
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (rx_busy && rx_cnt == '0) begin
			if (rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
				rx_shift <= {rx_sync[1], rx_shift[7:1]};
			end
			if (rx_bit == 4'd9) begin
				rx_data <= rx_shift;
			end
		end
	end

	// Bit 0 of the shifter is the line
	assign tx_out = tx_sr[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_sr <= '1;
			tx_empty <= 1'b1;
			tx_cnt <= '0;
			tx_bit <= '0;
		end else if (tx_empty) begin
			if (tx_latch) begin
				// Stop, data, start
				tx_sr <= {1'b1, tx_data, 1'b0};
				tx_empty <= 1'b0;
				tx_cnt <= FULL_BIT;
				tx_bit <= '0;
			end
		end else if (tx_cnt != '0) begin
			tx_cnt <= tx_cnt - CW'(1);
		end else begin
			tx_cnt <= FULL_BIT;
			tx_sr <= {1'b1, tx_sr[9:1]};
			tx_bit <= tx_bit + 4'd1;
			// Stop bit done
			if (tx_bit == 4'd9) begin
				tx_empty <= 1'b1;
			end
		end
	end

	// Controller loads only an idle transmitter
	assert property (@(posedge clk) disable iff (!rst_n) tx_latch |-> tx_empty)
		else $error("uart: tx_latch while the transmitter is busy");

endmodule

`default_nettype wire

// File: ice_bus_controller.sv
`timescale 1ns/1ps
`default_nettype none

module ice_bus_controller #(
	parameter int NUM_DEV = 2
) (
	input wire clk,
	input wire rst_n,
	input wire ice_bus_pkg::byte_t rx_char,
	input wire rx_char_valid,
	output ice_bus_pkg::byte_t tx_char,
	output logic tx_char_valid,
	input wire tx_char_ready,
	ice_bus_if.master bus
);

	import ice_bus_pkg::*;
	import ice_msg_pkg::*;

	localparam int PW = $clog2(TX_FIFO_DEPTH);
	localparam logic [PW:0] FULL_COUNT = (PW + 1)'(TX_FIFO_DEPTH);
	localparam logic [PW:0] HIGH_MARK = (PW + 1)'(TX_FIFO_DEPTH - TX_FIFO_SLACK);

	typedef enum logic [1:0] {P_ADDR, P_LEN, P_DATA, P_END} parse_t;

	parse_t state;
	byte_t remaining;
	logic nak_first;
	logic nak_second;

	logic [NUM_DEV-1:0] grant;
	byte_t dev_byte;
	logic dev_write;

	byte_t fifo_mem [TX_FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0] count;
	logic wr_en;
	logic rd_en;
	byte_t wr_data;

	// Frame parser
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= P_ADDR;
			remaining <= '0;
			bus.ma_frame_valid <= 1'b0;
			bus.ma_data_valid <= 1'b0;
		end else begin
			bus.ma_data_valid <= 1'b0;
			case (state)
				P_ADDR: begin
					if (rx_char_valid) begin
						bus.ma_frame_valid <= 1'b1;
						state <= P_LEN;
					end
				end
				P_LEN: begin
					if (rx_char_valid) begin
						remaining <= rx_char;
						state <= (rx_char == '0) ? P_END : P_DATA;
					end
				end
				P_DATA: begin
					if (rx_char_valid) begin
						bus.ma_data_valid <= 1'b1;
						remaining <= remaining - 8'd1;
						if (remaining == 8'd1) begin
							state <= P_END;
						end
					end
				end
				default: begin
					// Frame valid covers the last data strobe
					bus.ma_frame_valid <= 1'b0;
					state <= P_ADDR;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_char_valid && state == P_ADDR) begin
			bus.ma_addr <= rx_char;
		end
		if (rx_char_valid && state == P_DATA) begin
			bus.ma_data <= rx_char;
		end
	end

	// No device at this address
	assign nak_first = (state == P_END) && (bus.ma_addr >= byte_t'(NUM_DEV));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			nak_second <= 1'b0;
			grant <= '0;
		end else begin
			nak_second <= nak_first;
			if (grant == '0) begin
				// Lowest requesting index wins
				grant <= bus.sl_arb_request & (~bus.sl_arb_request + NUM_DEV'(1));
			end else if ((grant & bus.sl_arb_request) == '0) begin
				grant <= '0;
			end
		end
	end

	assign bus.sl_arb_grant = grant;

	always_comb begin
		dev_byte = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (grant[i]) begin
				dev_byte = bus.sl_data[i];
			end
		end
	end

	// Strobes without the grant are dropped
	assign dev_write = |(bus.sl_data_latch & grant);

	// NAK pair owns the write port for two cycles
	assign wr_en = nak_first | nak_second | dev_write;
	assign wr_data = nak_first ? NAK_CODE : (nak_second ? bus.ma_addr : dev_byte);
	assign bus.sl_overflow = (count > HIGH_MARK) | nak_first | nak_second;

	// Drain into the UART whenever it is idle
	assign rd_en = tx_char_ready && (count != '0);
	assign tx_char_valid = rd_en;
	assign tx_char = fifo_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + PW'(1);
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + PW'(1);
			end
			count <= count + (PW + 1)'(wr_en) - (PW + 1)'(rd_en);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			fifo_mem[wr_ptr] <= wr_data;
		end
	end

	// One owner of the reply path at a time
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
		else $error("ice_bus_controller: more than one grant");
	// Device stall lands before the FIFO fills
	assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> count != FULL_COUNT)
		else $error("ice_bus_controller: write into a full FIFO");

endmodule

`default_nettype wire

// File: basics_int.sv
`timescale 1ns/1ps
`default_nettype none

module basics_int (
	input wire clk,
	input wire rst_n,
	input wire ice_bus_pkg::gpio_word_t gpio_read,
	output ice_bus_pkg::gpio_word_t gpio_level,
	output ice_bus_pkg::gpio_word_t gpio_direction,
	ice_bus_if.device bus
);

	import ice_bus_pkg::*;
	import ice_msg_pkg::*;

	localparam byte_t MY_ADDR = byte_t'(ADDR_BASICS);

	logic mine;
	logic in_frame;
	logic pend;
	logic req;
	logic send;
	logic start;
	logic has_cmd;
	logic [2:0] idx;
	logic [2:0] left;
	logic [2:0] reply_len;
	byte_t cmd;
	gpio_word_t arg;
	logic [39:0] reply;
	logic [39:0] reply_next;

	assign mine = bus.ma_frame_valid && bus.ma_addr == MY_ADDR;
	// Reply built once the previous one is out
	assign start = pend && !req;
	assign has_cmd = idx != '0;
	assign send = req && bus.sl_arb_grant[ADDR_BASICS] && !bus.sl_overflow;

	assign bus.sl_arb_request[ADDR_BASICS] = req;
	assign bus.sl_data[ADDR_BASICS] = reply[39:32];
	assign bus.sl_data_latch[ADDR_BASICS] = send;

	always_comb begin
		// Unknown or missing command
		reply_len = 3'd3;
		reply_next = {MY_ADDR, 8'd1, NAK_CODE, 16'h0};
		if (has_cmd) begin
			case (cmd)
				CMD_VERSION: begin
					reply_len = 3'd4;
					reply_next = {MY_ADDR, 8'd2, VERSION_ID, 8'h0};
				end
				CMD_SET_DIR, CMD_SET_LEVEL: begin
					reply_len = 3'd2;
					reply_next = {MY_ADDR, 8'd0, 24'h0};
				end
				CMD_READ_GPIO: begin
					reply_len = 3'd5;
					reply_next = {MY_ADDR, 8'd3, gpio_read};
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_frame <= 1'b0;
			pend <= 1'b0;
			req <= 1'b0;
			idx <= '0;
			left <= '0;
			gpio_level <= '0;
			gpio_direction <= '0;
		end else begin
			in_frame <= mine;
			if (mine && !in_frame) begin
				idx <= '0;
			end
			// Count up to the command and three argument bytes
			if (mine && bus.ma_data_valid && idx != 3'd4) begin
				idx <= idx + 3'd1;
			end
			if (start) begin
				pend <= 1'b0;
				req <= 1'b1;
				left <= reply_len;
				if (has_cmd && cmd == CMD_SET_DIR) begin
					gpio_direction <= arg;
				end
				if (has_cmd && cmd == CMD_SET_LEVEL) begin
					gpio_level <= arg;
				end
			end
			// Falling edge of our frame
			if (in_frame && !mine) begin
				pend <= 1'b1;
			end
			if (send) begin
				left <= left - 3'd1;
				if (left == 3'd1) begin
					req <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mine && bus.ma_data_valid) begin
			if (idx == '0) begin
				cmd <= bus.ma_data;
			end else if (idx != 3'd4) begin
				// Argument arrives MSB first
				arg <= {arg[15:0], bus.ma_data};
			end
		end
		if (start) begin
			reply <= reply_next;
		end else if (send) begin
			reply <= {reply[31:0], 8'h0};
		end
	end

endmodule

`default_nettype wire

// File: gpio_int.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_int (
	input wire clk,
	input wire rst_n,
	input wire ice_bus_pkg::gpio_word_t gpio_in,
	input wire ice_bus_pkg::gpio_word_t gpio_level,
	input wire ice_bus_pkg::gpio_word_t gpio_direction,
	output ice_bus_pkg::gpio_word_t gpio_out,
	output ice_bus_pkg::gpio_word_t gpio_oe,
	output ice_bus_pkg::gpio_word_t gpio_sync,
	ice_bus_if.device bus
);

	import ice_bus_pkg::*;
	import ice_msg_pkg::*;

	localparam byte_t MY_ADDR = byte_t'(ADDR_GPIO);

	gpio_word_t sync1;
	gpio_word_t prev;
	logic pend;
	logic req;
	logic send;
	logic start;
	logic [2:0] left;
	byte_t tag;
	logic [47:0] report;

	// Direction bit set drives the pad
	assign gpio_out = gpio_level;
	assign gpio_oe = gpio_direction;

	assign start = pend && !req;
	assign send = req && bus.sl_arb_grant[ADDR_GPIO] && !bus.sl_overflow;

	assign bus.sl_arb_request[ADDR_GPIO] = req;
	assign bus.sl_data[ADDR_GPIO] = report[47:40];
	assign bus.sl_data_latch[ADDR_GPIO] = send;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync1 <= '0;
			gpio_sync <= '0;
			prev <= '0;
			pend <= 1'b0;
			req <= 1'b0;
			left <= '0;
			tag <= '0;
		end else begin
			// Two-flop pad synchronizer
			sync1 <= gpio_in;
			gpio_sync <= sync1;
			prev <= gpio_sync;
			if (start) begin
				pend <= 1'b0;
				req <= 1'b1;
				left <= 3'd6;
				tag <= tag + 8'd1;
			end
			// Input pins only
			if (((gpio_sync ^ prev) & ~gpio_direction) != '0) begin
				pend <= 1'b1;
			end
			if (send) begin
				left <= left - 3'd1;
				if (left == 3'd1) begin
					req <= 1'b0;
				end
			end
		end
	end

	// Later changes fold into a pending report
	always_ff @(posedge clk) begin
		if (start) begin
			report <= {MY_ADDR, 8'd4, tag, gpio_sync};
		end else if (send) begin
			report <= {report[39:0], 8'h0};
		end
	end

endmodule

`default_nettype wire

// File: ice_bus.sv
`timescale 1ns/1ps
`default_nettype none

module ice_bus #(
	parameter int NUM_DEV = 2,
	// 20 MHz clock at 115200 baud
	parameter int DIVIDE_FACTOR = 174
) (
	input wire clk,
	input wire rst_n,
	input wire uart_rx,
	output logic uart_tx,
	input wire ice_bus_pkg::gpio_word_t gpio_in,
	output ice_bus_pkg::gpio_word_t gpio_out,
	output ice_bus_pkg::gpio_word_t gpio_oe
);

	import ice_bus_pkg::*;

	byte_t rx_data;
	byte_t tx_data;
	logic rx_latch;
	logic tx_latch;
	logic tx_empty;
	gpio_word_t gpio_level;
	gpio_word_t gpio_direction;
	gpio_word_t gpio_sync;

	ice_bus_if #(.NUM_DEV(NUM_DEV)) bus ();

	// Host serial line
	uart #(.DIVIDE_FACTOR(DIVIDE_FACTOR)) u1 (
		.clk(clk),
		.rst_n(rst_n),
		.rx_in(uart_rx),
		.tx_out(uart_tx),
		.tx_latch(tx_latch),
		.tx_data(tx_data),
		.tx_empty(tx_empty),
		.rx_data(rx_data),
		.rx_latch(rx_latch)
	);

	ice_bus_controller #(.NUM_DEV(NUM_DEV)) ice1 (
		.clk(clk),
		.rst_n(rst_n),
		.rx_char(rx_data),
		.rx_char_valid(rx_latch),
		.tx_char(tx_data),
		.tx_char_valid(tx_latch),
		.tx_char_ready(tx_empty),
		.bus(bus)
	);

	// Version and GPIO settings, reads back the synchronized pads
	basics_int bi0 (
		.clk(clk),
		.rst_n(rst_n),
		.gpio_read(gpio_sync),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.bus(bus)
	);

	gpio_int gi1 (
		.clk(clk),
		.rst_n(rst_n),
		.gpio_in(gpio_in),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.gpio_sync(gpio_sync),
		.bus(bus)
	);

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS = 10
) (
	output logic clk
);

	// Free-running clock, low at time zero
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: ice_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ice_bus_tb;

	import ice_bus_pkg::*;
	import ice_msg_pkg::*;

	localparam int CLK_NS = 10;
	localparam int BIT_CLKS = 16;
	localparam int BYTE_CLKS = 10 * BIT_CLKS;
	// Host frames and event frames over the whole run
	localparam int NUM_FRAMES = 32;
	// Host bytes plus reply bytes of the longest exchange
	localparam int WORST_BYTES = 16;
	localparam int WATCHDOG_NS = NUM_FRAMES * WORST_BYTES * BYTE_CLKS * CLK_NS * 2;
	localparam int BYTE_WAIT = 40 * BYTE_CLKS;

	logic clk;
	logic rst_n;
	logic uart_rx;
	logic uart_tx;
	gpio_word_t gpio_in;
	gpio_word_t gpio_out;
	gpio_word_t gpio_oe;

	// Reference model state
	gpio_word_t pads_model;
	gpio_word_t dir_model;
	gpio_word_t level_model;
	byte_t tag_model;
	byte_t basics_q[$];
	byte_t gpio_q[$];
	byte_t nak_q[$];
	byte_t rx_q[$];
	byte_t frame_data[$];

	tb_clkgen #(.PERIOD_NS(CLK_NS)) clkgen0 (.clk(clk));

	ice_bus #(.DIVIDE_FACTOR(BIT_CLKS)) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			fail_run($sformatf("** Error at %0t: %s is %0h, expected %0h",
				$time, name, got, want));
		end
	endtask

	// 8N1 frame on uart_rx sent LSB first
	task automatic send_byte(input byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			uart_rx <= bits[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
	endtask

	// Address, length, then the bytes in frame_data
	task automatic send_frame(input byte_t addr);
		send_byte(addr);
		send_byte(byte_t'(frame_data.size()));
		foreach (frame_data[i]) begin
			send_byte(frame_data[i]);
		end
	endtask

	// Basics reply with body bytes taken from the top
	task automatic expect_basics(input byte_t len, input logic [23:0] body);
		basics_q.push_back(byte_t'(ADDR_BASICS));
		basics_q.push_back(len);
		for (int i = 0; i < int'(len); i++) begin
			basics_q.push_back(body[23 - 8 * i -: 8]);
		end
	endtask

	task automatic expect_event(input gpio_word_t pads);
		gpio_q.push_back(byte_t'(ADDR_GPIO));
		gpio_q.push_back(8'd4);
		gpio_q.push_back(tag_model);
		gpio_q.push_back(pads[23:16]);
		gpio_q.push_back(pads[15:8]);
		gpio_q.push_back(pads[7:0]);
		tag_model = tag_model + 8'd1;
	endtask

	task automatic query_version();
		frame_data.delete();
		frame_data.push_back(CMD_VERSION);
		expect_basics(8'd2, {VERSION_ID, 8'h00});
		send_frame(byte_t'(ADDR_BASICS));
	endtask

	// Flip random pads; an event is due only if an input pin moved
	task automatic change_pads(input logic outputs_only);
		gpio_word_t flip;
		flip = gpio_word_t'($urandom);
		if (outputs_only) begin
			flip = flip & dir_model;
		end else if ((flip & ~dir_model) == '0) begin
			flip = flip | 24'h1;
		end
		@(posedge clk);
		gpio_in <= pads_model ^ flip;
		pads_model = pads_model ^ flip;
		if ((flip & ~dir_model) != '0) begin
			expect_event(pads_model);
		end
	endtask

	task automatic get_byte(output byte_t b);
		int waited;
		waited = 0;
		while (rx_q.size() == 0 && waited < BYTE_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (rx_q.size() == 0) begin
			fail_run("No reply byte came out of uart_tx in time");
		end else begin
			b = rx_q.pop_front();
		end
	endtask

	// Source 0 basics, 1 GPIO, 2 NAK
	task automatic take_expected(input int src, input string name, input byte_t got);
		byte_t want;
		logic have;
		have = 1'b0;
		if (src == 0 && basics_q.size() != 0) begin
			want = basics_q.pop_front();
			have = 1'b1;
		end else if (src == 1 && gpio_q.size() != 0) begin
			want = gpio_q.pop_front();
			have = 1'b1;
		end else if (src == 2 && nak_q.size() != 0) begin
			want = nak_q.pop_front();
			have = 1'b1;
		end
		if (!have) begin
			fail_run($sformatf("Reply byte %h came with no reply outstanding", got));
		end else begin
			check_value(name, 32'(got), 32'(want));
		end
	endtask

	// A whole frame must arrive without bytes of another in between
	task automatic read_frame();
		byte_t first;
		byte_t len;
		byte_t b;
		int src;
		get_byte(first);
		if (first == NAK_CODE) begin
			take_expected(2, "nak code", first);
			get_byte(b);
			take_expected(2, "nak address", b);
		end else begin
			src = (first == 8'h01) ? 1 : 0;
			take_expected(src, "reply address", first);
			get_byte(len);
			take_expected(src, "reply length", len);
			for (int i = 0; i < int'(len); i++) begin
				get_byte(b);
				take_expected(src, "reply data", b);
			end
		end
	endtask

	task automatic drain_replies();
		while (basics_q.size() + gpio_q.size() + nak_q.size() != 0) begin
			read_frame();
		end
	endtask

	task automatic set_config(input byte_t cmd, input gpio_word_t value);
		frame_data.delete();
		frame_data.push_back(cmd);
		frame_data.push_back(value[23:16]);
		frame_data.push_back(value[15:8]);
		frame_data.push_back(value[7:0]);
		expect_basics(8'd0, 24'h0);
		send_frame(byte_t'(ADDR_BASICS));
		drain_replies();
	endtask

	// Serial receiver on uart_tx sampling mid-bit
	initial begin : serial_receiver
		byte_t b;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			if (uart_tx === 1'b0) begin
				repeat (BIT_CLKS / 2) @(negedge clk);
				if (uart_tx !== 1'b0) begin
					fail_run("Start bit on uart_tx was too short");
				end else begin
					for (int i = 0; i < 8; i++) begin
						repeat (BIT_CLKS) @(negedge clk);
						b[i] = uart_tx;
					end
					repeat (BIT_CLKS) @(negedge clk);
					if (uart_tx !== 1'b1) begin
						fail_run("Stop bit on uart_tx was low");
					end else begin
						rx_q.push_back(b);
					end
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		fail_run("Watchdog expired before the tests finished");
	end

	initial begin : stimulus
		gpio_word_t value;
		byte_t addr;
		int n;
		void'($urandom(51));
		rst_n <= 1'b0;
		uart_rx <= 1'b1;
		gpio_in <= '0;
		pads_model = '0;
		dir_model = '0;
		level_model = '0;
		tag_model = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// Idle line and pads released
		repeat (2 * BYTE_CLKS) begin
			@(negedge clk);
			check_value("uart_tx", 32'(uart_tx), 32'd1);
			check_value("gpio_oe", 32'(gpio_oe), 32'd0);
		end

		query_version();
		drain_replies();

		// Pad 0 kept an input so events can be forced
		for (int i = 0; i < 2; i++) begin
			value = gpio_word_t'($urandom);
			value[0] = 1'b0;
			set_config(CMD_SET_DIR, value);
			dir_model = value;
			@(negedge clk);
			check_value("gpio_oe", 32'(gpio_oe), 32'(dir_model));
			value = gpio_word_t'($urandom);
			set_config(CMD_SET_LEVEL, value);
			level_model = value;
			@(negedge clk);
			check_value("gpio_out", 32'(gpio_out), 32'(level_model));
			check_value("gpio_oe", 32'(gpio_oe), 32'(dir_model));
		end

		// Every third change touches output pins only
		for (int i = 0; i < 6; i++) begin
			change_pads(i % 3 == 2);
			repeat (8) @(posedge clk);
			frame_data.delete();
			frame_data.push_back(CMD_READ_GPIO);
			expect_basics(8'd3, pads_model);
			send_frame(byte_t'(ADDR_BASICS));
			drain_replies();
		end

		for (int i = 0; i < 3; i++) begin
			addr = byte_t'(32'd2 + $urandom % 32'd254);
			n = int'($urandom % 32'd6);
			frame_data.delete();
			for (int k = 0; k < n; k++) begin
				frame_data.push_back(byte_t'($urandom));
			end
			nak_q.push_back(NAK_CODE);
			nak_q.push_back(addr);
			send_frame(addr);
			drain_replies();
		end
		query_version();
		drain_replies();

		// Queries stream in while event reports compete for the FIFO
		fork
			begin
				for (int i = 0; i < 4; i++) begin
					query_version();
				end
			end
			begin
				repeat (40) @(posedge clk);
				change_pads(1'b0);
				repeat (6 * BYTE_CLKS) @(posedge clk);
				change_pads(1'b0);
			end
		join
		drain_replies();

		repeat (4 * BYTE_CLKS) @(posedge clk);
		if (rx_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			fail_run("The DUT sent reply bytes that no frame asked for");
		end
	end

endmodule

`default_nettype wire

// File: project.f
ice_bus_pkg.sv
ice_msg_pkg.sv
ice_bus_if.sv
uart.sv
ice_bus_controller.sv
basics_int.sv
gpio_int.sv
ice_bus.sv
tb_clkgen.sv
ice_bus_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module ice_bus

sim:
	verilator --binary --timing --assert -f project.f --top-module ice_bus_tb
	./obj_dir/Vice_bus_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
